//--- logic/sgmii_rx_pkg.sv
package sgmii_rx_pkg;

	//////////////////////////////
	// Code groups

	// Bit order is abcdei fghj, with a in bit 9 (first on the wire)
	// K28.5 sent while running disparity is negative
	localparam logic [9:0] K28_5_NEG = 10'b0011111010;
	// K28.5 sent while running disparity is positive
	localparam logic [9:0] K28_5_POS = 10'b1100000101;

	// Decoded control codes, packed as {is_ctl, data}
	// Start of packet /S/
	localparam logic [8:0] K27_7 = {1'b1, 8'hFB};
	// End of packet /T/
	localparam logic [8:0] K29_7 = {1'b1, 8'hFD};
	// Carrier extend /R/
	localparam logic [8:0] K23_7 = {1'b1, 8'hF7};
	// Comma, first byte of every idle ordered set
	localparam logic [8:0] K28_5_BYTE = {1'b1, 8'hBC};

	//////////////////////////////
	// Lock and link thresholds

	// Symbols without a comma before the decoder asks for a bitslip
	localparam int SLIP_WAIT = 24;
	// Consecutive bad symbols that drop the lock
	localparam int LOCK_LOSS = 4;
	// Clean commas the PCS must see before raising link_up
	localparam int IDLE_TO_LINK = 3;

	//////////////////////////////
	// State encodings

	// Comma alignment FSM in the decoder
	typedef enum logic [1:0] {
		LK_HUNT,
		LK_SLIP_WAIT,
		LK_LOCKED
	} lock_state_t;

	// Receive PCS FSM
	typedef enum logic [1:0] {
		PCS_DOWN,
		PCS_IDLE,
		PCS_FRAME
	} pcs_state_t;

endpackage

//--- logic/decoded_if.sv
`timescale 1ns/1ns

// Decoded byte stream between the 8b/10b decoder and the receive PCS
interface decoded_if;

	// One byte per cycle with data_valid high
	logic		data_valid;
	logic [7:0]	data;
	// Byte came from a K code group
	logic		is_ctl;
	// Group not in the code tables
	logic		code_err;
	// Group broke the running disparity
	logic		disp_err;
	// Decoder is word aligned
	logic		locked;

	modport source (
		output data_valid, data, is_ctl, code_err, disp_err, locked
	);

	modport sink (
		input data_valid, data, is_ctl, code_err, disp_err, locked
	);

endinterface

//--- logic/rx_gearbox.sv
`timescale 1ns/1ns

// 8 to 10 bit gearbox with bitslip
// Four symbols leave for every five words in steady state
module rx_gearbox (
	input  logic		symbol_clk,
	input  logic		rst_n,
	input  logic [7:0]	rx_word,
	input  logic		bitslip,
	output logic		symbol_valid,
	output logic [9:0]	symbol
);

	//////////////////////////////
	// Bit window

	// Leftover bits, right justified, oldest at hold_q[cnt_q-1]
	logic [8:0]		hold_q;
	// Leftover bit count, never above 9
	logic [3:0]		cnt_q;
	// Leftovers plus the new word, 17 bits at most in use
	logic [16:0]	window;
	// Bits held once the word is appended
	logic [4:0]		total;
	// Same, after a bitslip throws away the oldest bit
	logic [4:0]		avail;

	assign window = {hold_q, rx_word};
	assign total = cnt_q + 5'd8;
	// Dropping the oldest bit just shortens the window from the top
	assign avail = total - {4'd0, bitslip};

	//////////////////////////////
	// Fill count and strobe

	always_ff @(posedge symbol_clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
			symbol_valid <= 1'b0;
		end else begin
			// A full symbol is ready, strobe it on the next cycle
			symbol_valid <= (avail >= 5'd10);
			if (avail >= 5'd10) begin
				cnt_q <= 4'(avail - 5'd10);
			end else begin
				cnt_q <= avail[3:0];
			end
		end
	end

	//////////////////////////////
	// Data path

	always_ff @(posedge symbol_clk) begin
		// Low bits always hold whatever is left over
		hold_q <= window[8:0];
		// Oldest ten bits form the symbol, bit 9 first on the wire
		if (avail >= 5'd10) begin
			symbol <= window[avail - 5'd1 -: 10];
		end
	end

endmodule

//--- logic/decode_8b10b.sv
`timescale 1ns/1ns

// 8b/10b decoder with running disparity check and comma alignment
module decode_8b10b import sgmii_rx_pkg::*; (
	input  logic		symbol_clk,
	input  logic		rst_n,
	input  logic		symbol_valid,
	input  logic [9:0]	symbol,
	output logic		bitslip,
	decoded_if.source	dec
);

	//////////////////////////////
	// Code tables

	// 6b to 5b, returns {ok, EDCBA}, both disparities listed
	function automatic logic [5:0] dec6(input logic [5:0] c);
		logic [5:0] r;
		case (c)
			6'b100111, 6'b011000: r = {1'b1, 5'd0};
			6'b011101, 6'b100010: r = {1'b1, 5'd1};
			6'b101101, 6'b010010: r = {1'b1, 5'd2};
			6'b110001: r = {1'b1, 5'd3};
			6'b110101, 6'b001010: r = {1'b1, 5'd4};
			6'b101001: r = {1'b1, 5'd5};
			6'b011001: r = {1'b1, 5'd6};
			6'b111000, 6'b000111: r = {1'b1, 5'd7};
			6'b111001, 6'b000110: r = {1'b1, 5'd8};
			6'b100101: r = {1'b1, 5'd9};
			6'b010101: r = {1'b1, 5'd10};
			6'b110100: r = {1'b1, 5'd11};
			6'b001101: r = {1'b1, 5'd12};
			6'b101100: r = {1'b1, 5'd13};
			6'b011100: r = {1'b1, 5'd14};
			6'b010111, 6'b101000: r = {1'b1, 5'd15};
			6'b011011, 6'b100100: r = {1'b1, 5'd16};
			6'b100011: r = {1'b1, 5'd17};
			6'b010011: r = {1'b1, 5'd18};
			6'b110010: r = {1'b1, 5'd19};
			6'b001011: r = {1'b1, 5'd20};
			6'b101010: r = {1'b1, 5'd21};
			6'b011010: r = {1'b1, 5'd22};
			6'b111010, 6'b000101: r = {1'b1, 5'd23};
			6'b110011, 6'b001100: r = {1'b1, 5'd24};
			6'b100110: r = {1'b1, 5'd25};
			6'b010110: r = {1'b1, 5'd26};
			6'b110110, 6'b001001: r = {1'b1, 5'd27};
			// D.28 and the K28 pair
			6'b001110, 6'b001111, 6'b110000: r = {1'b1, 5'd28};
			6'b101110, 6'b010001: r = {1'b1, 5'd29};
			6'b011110, 6'b100001: r = {1'b1, 5'd30};
			6'b101011, 6'b010100: r = {1'b1, 5'd31};
			default: r = 6'd0;
		endcase
		return r;
	endfunction

	// 4b to 3b, returns {ok, HGF}, primary and alternate 7 both map to 7
	function automatic logic [3:0] dec4(input logic [3:0] c);
		logic [3:0] r;
		case (c)
			4'b1011, 4'b0100: r = {1'b1, 3'd0};
			4'b1001: r = {1'b1, 3'd1};
			4'b0101: r = {1'b1, 3'd2};
			4'b1100, 4'b0011: r = {1'b1, 3'd3};
			4'b1101, 4'b0010: r = {1'b1, 3'd4};
			4'b1010: r = {1'b1, 3'd5};
			4'b0110: r = {1'b1, 3'd6};
			4'b1110, 4'b0001, 4'b0111, 4'b1000: r = {1'b1, 3'd7};
			default: r = 4'd0;
		endcase
		return r;
	endfunction

	//////////////////////////////
	// Symbol decode

	lock_state_t	state_q;
	lock_state_t	state_d;
	logic [$clog2(SLIP_WAIT)-1:0]	cnt_q;
	logic [$clog2(SLIP_WAIT)-1:0]	cnt_d;
	logic [$clog2(LOCK_LOSS)-1:0]	err_cnt_q;
	logic [$clog2(LOCK_LOSS)-1:0]	err_d;
	logic			slip_d;
	// Running disparity, 1 is positive
	logic			rd_q;
	logic			rd_mid;
	logic			rd_next;
	logic			bad_rd6;
	logic			bad_rd4;
	int				pop6;
	int				pop4;
	logic [3:0]		sub4;
	logic [5:0]		lut6;
	logic [3:0]		lut4;
	logic			k28;
	logic			a7;
	logic			kx7;
	logic			a7_ok;
	logic			comma;
	logic			sym_ctl;
	logic			sym_code_err;
	logic			sym_disp_err;
	logic			sym_bad;

	always_comb begin
		k28 = (symbol[9:4] == K28_5_NEG[9:4]) || (symbol[9:4] == K28_5_POS[9:4]);
		// K28 after 110000 carries the inverted 4b sub-block
		sub4 = (symbol[9:4] == K28_5_POS[9:4]) ? ~symbol[3:0] : symbol[3:0];
		lut6 = dec6(symbol[9:4]);
		lut4 = dec4(sub4);
		pop6 = $countones(symbol[9:4]);
		pop4 = $countones(symbol[3:0]);

		// 6b block against incoming disparity
		rd_mid = rd_q;
		bad_rd6 = 1'b0;
		if (pop6 == 4) begin
			bad_rd6 = rd_q;
			rd_mid = 1'b1;
		end else if (pop6 == 2) begin
			bad_rd6 = !rd_q;
			rd_mid = 1'b0;
		end else if (symbol[9:4] == 6'b111000) begin
			bad_rd6 = rd_q;
		end else if (symbol[9:4] == 6'b000111) begin
			bad_rd6 = !rd_q;
		end

		// 4b block against disparity left by the 6b block
		rd_next = rd_mid;
		bad_rd4 = 1'b0;
		if (pop4 == 3) begin
			bad_rd4 = rd_mid;
			rd_next = 1'b1;
		end else if (pop4 == 1) begin
			bad_rd4 = !rd_mid;
			rd_next = 1'b0;
		end else if (symbol[3:0] == 4'b1100) begin
			bad_rd4 = rd_mid;
		end else if (symbol[3:0] == 4'b0011) begin
			bad_rd4 = !rd_mid;
		end

		// Alternate 7 is K23/27/29/30.7, or data only after a few codes
		a7 = (symbol[3:0] == 4'b0111) || (symbol[3:0] == 4'b1000);
		kx7 = a7 && (lut6[4:0] inside {5'd23, 5'd27, 5'd29, 5'd30});
		a7_ok = lut6[4:0] inside {5'd11, 5'd13, 5'd14, 5'd17, 5'd18, 5'd20};
		comma = (symbol == K28_5_NEG) || (symbol == K28_5_POS);
		sym_ctl = k28 || kx7;
		sym_code_err = !lut6[5] || !lut4[3] || (a7 && !k28 && !kx7 && !a7_ok);
		// Disparity only means something once aligned
		sym_disp_err = (bad_rd6 || bad_rd4) && (state_q == LK_LOCKED);
		sym_bad = sym_code_err || sym_disp_err;
	end

	//////////////////////////////
	// Comma lock FSM

	always_comb begin
		state_d = state_q;
		cnt_d = cnt_q;
		err_d = err_cnt_q;
		slip_d = 1'b0;
		if (symbol_valid) begin
			case (state_q)
				LK_HUNT: begin
					if (comma) begin
						state_d = LK_LOCKED;
						err_d = '0;
					end else if (int'(cnt_q) == SLIP_WAIT - 1) begin
						// No comma in the window, move the boundary one bit
						state_d = LK_SLIP_WAIT;
						cnt_d = '0;
						slip_d = 1'b1;
					end else begin
						cnt_d = cnt_q + 1'b1;
					end
				end
				LK_SLIP_WAIT: begin
					// Let two symbols drain before hunting again
					if (cnt_q != '0) begin
						state_d = LK_HUNT;
						cnt_d = '0;
					end else begin
						cnt_d = cnt_q + 1'b1;
					end
				end
				default: begin
					if (!sym_bad) begin
						err_d = '0;
					end else if (int'(err_cnt_q) == LOCK_LOSS - 1) begin
						state_d = LK_HUNT;
						cnt_d = '0;
					end else begin
						err_d = err_cnt_q + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge symbol_clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= LK_HUNT;
			cnt_q <= '0;
			err_cnt_q <= '0;
			bitslip <= 1'b0;
			rd_q <= 1'b0;
			dec.data_valid <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q <= cnt_d;
			err_cnt_q <= err_d;
			bitslip <= slip_d;
			if (symbol_valid) begin
				rd_q <= rd_next;
			end
			// The comma that wins lock is passed on too
			dec.data_valid <= symbol_valid && (state_d == LK_LOCKED);
		end
	end

	// Decoded byte and flags
	always_ff @(posedge symbol_clk) begin
		if (symbol_valid) begin
			dec.data <= {lut4[2:0], lut6[4:0]};
			dec.is_ctl <= sym_ctl;
			dec.code_err <= sym_code_err;
			dec.disp_err <= sym_disp_err;
		end
	end

	assign dec.locked = (state_q == LK_LOCKED);

endmodule

//--- logic/pcs_rx.sv
`timescale 1ns/1ns

// 1000BASE-X receive PCS, ordered sets to GMII receive bytes
module pcs_rx import sgmii_rx_pkg::*; (
	input  logic		symbol_clk,
	input  logic		rst_n,
	decoded_if.sink		dec,
	output logic		gmii_rx_valid,
	output logic		gmii_rx_dv,
	output logic		gmii_rx_er,
	output logic [7:0]	gmii_rxd,
	output logic		link_up
);

	pcs_state_t		state_q;
	// Clean commas seen so far while the link is down
	logic [$clog2(IDLE_TO_LINK)-1:0]	idle_cnt_q;
	logic [8:0]		code;
	logic			byte_bad;
	logic			sof;

	assign code = {dec.is_ctl, dec.data};
	assign byte_bad = dec.code_err || dec.disp_err;
	// Clean /S/ between frames opens a new frame
	assign sof = dec.locked && (state_q == PCS_IDLE) && (code == K27_7) && !byte_bad;
	assign link_up = (state_q != PCS_DOWN);

	//////////////////////////////
	// Link and frame FSM

	always_ff @(posedge symbol_clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= PCS_DOWN;
			idle_cnt_q <= '0;
			gmii_rx_valid <= 1'b0;
			gmii_rx_dv <= 1'b0;
			gmii_rx_er <= 1'b0;
		end else begin
			// Every decoded byte gives one GMII strobe
			gmii_rx_valid <= dec.data_valid;
			if (!dec.locked) begin
				// Alignment gone, start over
				state_q <= PCS_DOWN;
				idle_cnt_q <= '0;
				gmii_rx_dv <= 1'b0;
				gmii_rx_er <= 1'b0;
			end else if (dec.data_valid) begin
				gmii_rx_dv <= 1'b0;
				gmii_rx_er <= 1'b0;
				case (state_q)
					PCS_DOWN: begin
						if (code == K28_5_BYTE && !byte_bad) begin
							if (int'(idle_cnt_q) == IDLE_TO_LINK - 1) begin
								state_q <= PCS_IDLE;
								idle_cnt_q <= '0;
							end else begin
								idle_cnt_q <= idle_cnt_q + 1'b1;
							end
						end else if (byte_bad) begin
							idle_cnt_q <= '0;
						end
					end
					PCS_IDLE: begin
						// Idles and /R/ give strobes with dv low
						if (sof) begin
							state_q <= PCS_FRAME;
							gmii_rx_dv <= 1'b1;
						end
					end
					default: begin
						if (code == K29_7) begin
							state_q <= PCS_IDLE;
						end else if (code == K28_5_BYTE) begin
							// Frame cut short by an idle
							state_q <= PCS_IDLE;
							gmii_rx_dv <= 1'b1;
							gmii_rx_er <= 1'b1;
						end else begin
							gmii_rx_dv <= 1'b1;
							// Bad group or stray K code inside the frame
							gmii_rx_er <= byte_bad || dec.is_ctl;
						end
					end
				endcase
			end
		end
	end

	// /S/ goes out as the first preamble byte
	always_ff @(posedge symbol_clk) begin
		if (dec.data_valid) begin
			gmii_rxd <= sof ? 8'h55 : dec.data;
		end
	end

endmodule

//--- logic/sgmii_rx_bridge.sv
`timescale 1ns/1ns

// SGMII receive path, deserializer words in, GMII bytes out
module sgmii_rx_bridge (
	input  logic		symbol_clk,
	input  logic		rst_n,
	// First-arrived bit in bit 7
	input  logic [7:0]	rx_word,
	output logic		gmii_rx_valid,
	output logic		gmii_rx_dv,
	output logic		gmii_rx_er,
	output logic [7:0]	gmii_rxd,
	output logic		link_up,
	output logic		locked
);

	//////////////////////////////
	// Gearbox

	logic		symbol_valid;
	logic [9:0]	symbol;
	logic		bitslip;

	rx_gearbox i_gearbox (
		.symbol_clk		(symbol_clk),
		.rst_n			(rst_n),
		.rx_word		(rx_word),
		.bitslip		(bitslip),
		.symbol_valid	(symbol_valid),
		.symbol			(symbol)
	);

	//////////////////////////////
	// 8b/10b decode

	decoded_if dec_bus ();

	decode_8b10b i_decoder (
		.symbol_clk		(symbol_clk),
		.rst_n			(rst_n),
		.symbol_valid	(symbol_valid),
		.symbol			(symbol),
		.bitslip		(bitslip),
		.dec			(dec_bus.source)
	);

	assign locked = dec_bus.locked;

	//////////////////////////////
	// Receive PCS

	pcs_rx i_pcs (
		.symbol_clk		(symbol_clk),
		.rst_n			(rst_n),
		.dec			(dec_bus.sink),
		.gmii_rx_valid	(gmii_rx_valid),
		.gmii_rx_dv		(gmii_rx_dv),
		.gmii_rx_er		(gmii_rx_er),
		.gmii_rxd		(gmii_rxd),
		.link_up		(link_up)
	);

endmodule

//--- tests/sgmii_rx_props.sv
`timescale 1ns/1ns

// Lock and strobe rules of the 8b/10b decoder
module sgmii_rx_props (
	input  logic	symbol_clk,
	input  logic	rst_n,
	input  logic	symbol_valid,
	input  logic	bitslip,
	input  logic	data_valid,
	input  logic	locked
);

	// Aligned decoder never moves the boundary
	assert property (@(posedge symbol_clk) disable iff (!rst_n) !(bitslip && locked))
		else $error("bitslip pulsed while the decoder was locked");

	// One cycle from symbol to byte
	assert property (@(posedge symbol_clk) disable iff (!rst_n) data_valid |-> $past(symbol_valid))
		else $error("data_valid without symbol_valid one cycle before");

	// Bytes only leave an aligned decoder
	assert property (@(posedge symbol_clk) disable iff (!rst_n) data_valid |-> locked)
		else $error("data_valid high while the decoder was unlocked");

endmodule

bind decode_8b10b sgmii_rx_props i_props (
	.symbol_clk		(symbol_clk),
	.rst_n			(rst_n),
	.symbol_valid	(symbol_valid),
	.bitslip		(bitslip),
	.data_valid		(dec.data_valid),
	.locked			(dec.locked)
);

//--- tests/sgmii_rx_checker.sv
`timescale 1ns/1ns

// Watches the GMII side and compares frame bytes with the expected queue
module sgmii_rx_checker (
	input  logic		symbol_clk,
	input  logic		rst_n,
	input  logic		gmii_rx_valid,
	input  logic		gmii_rx_dv,
	input  logic		gmii_rx_er,
	input  logic [7:0]	gmii_rxd,
	input  logic		link_up,
	input  logic		locked
);

	// Expected frame bytes, one entry per strobe with dv high
	string		name_q[$];
	logic [7:0]	data_q[$];
	logic		er_q[$];
	logic		chk_q[$];

	int			error_count = 0;
	int			idle_strobes = 0;
	int			lock_drops = 0;
	int			link_drops = 0;
	logic		locked_d = 1'b0;
	logic		link_d = 1'b0;

	task automatic push_expected(input string name, input logic [7:0] data,
			input logic er, input logic check_data);
		name_q.push_back(name);
		data_q.push_back(data);
		er_q.push_back(er);
		chk_q.push_back(check_data);
	endtask

	function automatic int pending();
		return data_q.size();
	endfunction

	always @(posedge symbol_clk) begin : watch
		string		name;
		logic [7:0]	exp_data;
		logic		exp_er;
		logic		exp_chk;
		if (rst_n) begin
			// Falling edges of lock and link
			if (locked_d && !locked) lock_drops++;
			if (link_d && !link_up) link_drops++;
			if (!link_d && link_up && !locked) begin
				$display("link_up rose while the decoder was not locked");
				error_count++;
			end
			locked_d = locked;
			link_d = link_up;
			// Idle and /R/ strobes stay out of the queue
			if (gmii_rx_valid && !gmii_rx_dv) idle_strobes++;
			if (gmii_rx_valid && gmii_rx_dv) begin
				if (!link_up) begin
					$display("Frame byte %h seen while link_up was low", gmii_rxd);
					error_count++;
				end
				if (data_q.size() == 0) begin
					$display("Frame byte %h arrived with nothing expected", gmii_rxd);
					error_count++;
				end else begin
					name = name_q.pop_front();
					exp_data = data_q.pop_front();
					exp_er = er_q.pop_front();
					exp_chk = chk_q.pop_front();
					if (gmii_rx_er !== exp_er) begin
						$display("Fail %s: rx_er expected %b actual %b", name, exp_er,
							gmii_rx_er);
						error_count++;
					end
					// Data of a broken group carries no meaning
					if (exp_chk && gmii_rxd !== exp_data) begin
						$display("Fail %s: rxd expected %h actual %h", name, exp_data,
							gmii_rxd);
						error_count++;
					end
				end
			end
		end
	end

endmodule

//--- tests/sgmii_rx_tb.sv
`timescale 1ns/1ns

module sgmii_rx_tb import sgmii_rx_pkg::*; ();

	localparam int NUM_TESTS = 6;
	localparam int MAX_LEN = 16;
	// Idle ordered sets after each frame
	localparam int GAP_IDLES = 6;
	// Bounds on idle sets while polling lock and link
	localparam int HUNT_POLL = SLIP_WAIT * 6;
	localparam int LINK_POLL = 12;
	localparam int FLUSH_IDLES = 10;

	// Test modes
	localparam int M_PLAIN = 0;
	localparam int M_CODE = 1;
	localparam int M_DISP = 2;
	localparam int M_RELOCK = 3;

	logic		symbol_clk;
	logic		rst_n;
	logic [7:0]	rx_word;
	logic		gmii_rx_valid;
	logic		gmii_rx_dv;
	logic		gmii_rx_er;
	logic [7:0]	gmii_rxd;
	logic		link_up;
	logic		locked;

	//////////////////////////////
	// Stimulus table

	string		test_name [NUM_TESTS];
	int			test_mode [NUM_TESTS];
	int			test_len [NUM_TESTS];
	// Byte index with the injected error, rx_er is expected there
	int			test_inj [NUM_TESTS];
	logic [7:0]	test_bytes [NUM_TESTS][MAX_LEN];

	// Serial bits not yet packed into a word, oldest first
	logic		bits_q[$];
	// Running disparity of the reference encoder, 1 is positive
	logic		rd;
	int			tb_errors;

	sgmii_rx_bridge i_dut (
		.symbol_clk		(symbol_clk),
		.rst_n			(rst_n),
		.rx_word		(rx_word),
		.gmii_rx_valid	(gmii_rx_valid),
		.gmii_rx_dv		(gmii_rx_dv),
		.gmii_rx_er		(gmii_rx_er),
		.gmii_rxd		(gmii_rxd),
		.link_up		(link_up),
		.locked			(locked)
	);

	sgmii_rx_checker i_checker (
		.symbol_clk		(symbol_clk),
		.rst_n			(rst_n),
		.gmii_rx_valid	(gmii_rx_valid),
		.gmii_rx_dv		(gmii_rx_dv),
		.gmii_rx_er		(gmii_rx_er),
		.gmii_rxd		(gmii_rxd),
		.link_up		(link_up),
		.locked			(locked)
	);

	initial begin
		symbol_clk = 1'b0;
		forever #10 symbol_clk = ~symbol_clk;
	end

	//////////////////////////////
	// Reference 8b/10b encoder

	// 5b to abcdei, the form sent at negative disparity
	function automatic logic [5:0] code6_neg(input logic [4:0] x);
		logic [5:0] t [32];
		t = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001,
			6'b011001, 6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100,
			6'b001101, 6'b101100, 6'b011100, 6'b010111, 6'b011011, 6'b100011,
			6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
			6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110,
			6'b011110, 6'b101011};
		return t[x];
	endfunction

	// 3b to fghj at negative disparity, primary 7
	function automatic logic [3:0] code4_neg(input logic [2:0] y);
		logic [3:0] t [8];
		t = '{4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
		return t[y];
	endfunction

	// Returns {disparity out, code group}
	function automatic logic [10:0] encode_group(input logic [7:0] d, input logic k,
			input logic rd_in);
		logic [4:0] x;
		logic [2:0] y;
		logic [5:0] c6;
		logic [3:0] c4;
		logic		rd_mid;
		logic		alt;
		int			p6;
		int			p4;
		x = d[4:0];
		y = d[7:5];
		if (k && d == 8'hBC) begin
			return rd_in ? {1'b0, K28_5_POS} : {1'b1, K28_5_NEG};
		end
		c6 = code6_neg(x);
		p6 = $countones(c6);
		if (rd_in && (p6 != 3 || x == 5'd7)) c6 = ~c6;
		rd_mid = (p6 == 3) ? rd_in : !rd_in;
		// Alternate 7 avoids a run of five inside data, always used by K codes
		alt = k || (y == 3'd7 && (rd_mid ? (x inside {5'd11, 5'd13, 5'd14})
			: (x inside {5'd17, 5'd18, 5'd20})));
		if (alt) begin
			c4 = rd_mid ? 4'b1000 : 4'b0111;
			p4 = 3;
		end else begin
			c4 = code4_neg(y);
			p4 = $countones(c4);
			if (rd_mid && (p4 != 2 || y == 3'd3)) c4 = ~c4;
		end
		return {(p4 == 2) ? rd_mid : !rd_mid, c6, c4};
	endfunction

	//////////////////////////////
	// Serializer

	// Bits leave MSB first, eight per cycle, 2 ns after the edge
	task automatic send_symbol(input logic [9:0] s);
		logic [7:0] w;
		for (int i = 9; i >= 0; i--) bits_q.push_back(s[i]);
		while (bits_q.size() >= 8) begin
			for (int i = 7; i >= 0; i--) w[i] = bits_q.pop_front();
			@(posedge symbol_clk);
			#2 rx_word = w;
		end
	endtask

	task automatic send_byte(input logic [7:0] d, input logic k);
		logic [10:0] r;
		r = encode_group(d, k, rd);
		rd = r[10];
		send_symbol(r[9:0]);
	endtask

	// /I2/ ordered set, K28.5 then D16.2
	task automatic send_idle();
		send_byte(K28_5_BYTE[7:0], 1'b1);
		send_byte(8'h50, 1'b0);
	endtask

	// Idles until both lock and link are up, or the bound runs out
	task automatic wait_link(input int bound, output int sets);
		sets = 0;
		while (!(locked && link_up) && sets < bound) begin
			send_idle();
			sets++;
		end
	endtask

	task automatic send_frame(input int t);
		logic [10:0]	r;
		logic [7:0]		d;
		send_byte(K27_7[7:0], 1'b1);
		i_checker.push_expected(test_name[t], 8'h55, 1'b0, 1'b1);
		for (int i = 0; i < test_len[t]; i++) begin
			d = test_bytes[t][i];
			if (i == test_inj[t] && test_mode[t] == M_CODE) begin
				// All-zero group is in neither table
				send_symbol(10'b0000000000);
				i_checker.push_expected(test_name[t], d, 1'b1, 1'b0);
			end else if (i == test_inj[t] && test_mode[t] == M_DISP) begin
				// Encoded at the opposite disparity
				r = encode_group(d, 1'b0, !rd);
				rd = r[10];
				send_symbol(r[9:0]);
				i_checker.push_expected(test_name[t], d, 1'b1, 1'b1);
			end else begin
				send_byte(d, 1'b0);
				i_checker.push_expected(test_name[t], d, 1'b0, 1'b1);
			end
		end
		send_byte(K29_7[7:0], 1'b1);
		send_byte(K23_7[7:0], 1'b1);
		repeat (GAP_IDLES) send_idle();
	endtask

	task automatic fill_table();
		test_name = '{"frame_short", "frame_alt7", "frame_rand", "bad_code", "bad_disp",
			"lock_loss"};
		test_mode = '{M_PLAIN, M_PLAIN, M_PLAIN, M_CODE, M_DISP, M_RELOCK};
		test_len = '{4, 8, 12, 8, 8, 6};
		test_inj = '{-1, -1, -1, 3, 5, -1};
		for (int t = 0; t < NUM_TESTS; t++) begin
			for (int i = 0; i < MAX_LEN; i++) test_bytes[t][i] = 8'hA0 + 8'(t * 16 + i);
		end
		// x.7 bytes that need the alternate 4b code
		test_bytes[1] = '{8'hEB, 8'hF1, 8'hED, 8'hF2, 8'hEE, 8'hF4, 8'hE7, 8'hFB,
			8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
		for (int i = 0; i < MAX_LEN; i++) test_bytes[2][i] = 8'($urandom);
		// D0.0 has an unbalanced 6b block, so disparity resyncs after it
		test_bytes[4][5] = 8'h00;
	endtask

	// Symbols the table sends, lock hunting excluded
	function automatic int table_symbols();
		int n;
		n = 2 * (LINK_POLL * 3 + FLUSH_IDLES) + LOCK_LOSS;
		for (int t = 0; t < NUM_TESTS; t++) n += test_len[t] + 3 + 2 * GAP_IDLES;
		return n;
	endfunction

	//////////////////////////////
	// Main sequence

	initial begin : main
		int		offset;
		int		sets;
		int		lock_before;
		int		link_before;
		longint	limit_ns;
		rx_word = 8'h00;
		rst_n = 1'b0;
		rd = 1'b0;
		tb_errors = 0;
		void'($urandom(32'hf431_02a4));
		fill_table();
		// 1.25 cycles of 20 ns per symbol
		limit_ns = longint'(table_symbols() + SLIP_WAIT * 12) * 25 + 4000;
		fork
			begin
				#(limit_ns);
				$display("Watchdog expired after %0d ns, stimulus never finished", limit_ns);
				$display("Regression failed");
				$finish;
			end
		join_none
		repeat (2) @(posedge symbol_clk);
		#2 rst_n = 1'b1;

		// Random bit offset ahead of the first group
		offset = $urandom % 10;
		for (int i = 0; i < offset; i++) bits_q.push_back(1'($urandom));
		sets = 0;
		while (!locked && sets < HUNT_POLL) begin
			send_idle();
			sets++;
		end
		if (!locked) begin
			$display("Decoder did not lock from bit offset %0d", offset);
			tb_errors++;
		end
		wait_link(LINK_POLL, sets);
		if (!link_up) begin
			$display("link_up did not rise after lock");
			tb_errors++;
		end else if (sets > IDLE_TO_LINK + 2) begin
			$display("link_up needed %0d idles after lock", sets);
			tb_errors++;
		end

		for (int t = 0; t < NUM_TESTS; t++) begin
			if (test_mode[t] == M_RELOCK) begin
				lock_before = i_checker.lock_drops;
				link_before = i_checker.link_drops;
				repeat (LOCK_LOSS) send_symbol(10'b0000000000);
				// Keep the line busy until the bad groups have dropped the link
				sets = 0;
				while (i_checker.link_drops == link_before && sets < LINK_POLL) begin
					send_idle();
					sets++;
				end
				wait_link(LINK_POLL, sets);
				if (i_checker.lock_drops == lock_before
						|| i_checker.link_drops == link_before) begin
					$display("%s: bad symbols did not drop lock and link", test_name[t]);
					tb_errors++;
				end
				if (!(locked && link_up)) begin
					$display("%s: lock and link did not come back", test_name[t]);
					tb_errors++;
				end
			end
			send_frame(t);
		end

		repeat (FLUSH_IDLES) send_idle();
		if (i_checker.pending() != 0) begin
			$display("%0d expected frame bytes never arrived", i_checker.pending());
			tb_errors++;
		end
		if (i_checker.idle_strobes == 0) begin
			$display("No idle strobes with rx_dv low were seen");
			tb_errors++;
		end
		$display("Errors: checker %0d, testbench %0d", i_checker.error_count, tb_errors);
		if (i_checker.error_count == 0 && tb_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- sgmii_rx_bridge.f
logic/sgmii_rx_pkg.sv
logic/decoded_if.sv
logic/rx_gearbox.sv
logic/decode_8b10b.sv
logic/pcs_rx.sv
logic/sgmii_rx_bridge.sv
tests/sgmii_rx_props.sv
tests/sgmii_rx_checker.sv
tests/sgmii_rx_tb.sv

//--- Makefile
# Verilator simulation of the SGMII receive bridge

VERILATOR ?= verilator
TOP       ?= sgmii_rx_tb
FILELIST  ?= sgmii_rx_bridge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
